/* bench/mesh_input.txt */
# mode(0 plain, 1 random wait_in, 2 latency) write datamode ctrlmode dstaddr data srcaddr expect
# all fields hex, expect is the read data due back and 0 for writes
0 1 2 00 80000000 11110000 00000000 00000000
0 1 2 01 80001080 22220001 00000000 00000000
0 0 2 02 80000000 00000000 40000100 11110000
0 0 2 03 80001080 00000000 40000104 22220001
0 1 2 04 80000004 a5a55a5a 00000000 00000000
0 1 2 05 80001084 5a5aa5a5 00000000 00000000
0 0 2 06 80000004 00000000 40000108 a5a55a5a
0 0 2 07 80001084 00000000 4000010c 5a5aa5a5
0 0 2 08 80000000 00000000 40000110 11110000
0 0 2 09 80001080 00000000 40000114 22220001
0 1 2 0a 80000000 deadbeef 00000000 00000000
0 0 2 0b 80000000 00000000 40000118 deadbeef
0 0 2 0c 80001080 00000000 4000011c 22220001
1 1 2 0d 80000008 01234567 00000000 00000000
1 1 2 0e 80001088 89abcdef 00000000 00000000
1 0 2 0f 80000008 00000000 40000200 01234567
1 0 2 10 80001088 00000000 40000204 89abcdef
1 0 2 11 80000004 00000000 40000208 a5a55a5a
1 0 2 12 80001084 00000000 4000020c 5a5aa5a5
1 0 2 13 80000008 00000000 40000210 01234567
1 0 2 14 80001080 00000000 40000214 22220001
1 1 2 15 80001080 cafef00d 00000000 00000000
1 0 2 16 80001080 00000000 40000218 cafef00d
1 0 2 17 80000000 00000000 4000021c deadbeef
1 0 2 18 80000004 00000000 40000220 a5a55a5a
1 0 2 19 80001088 00000000 40000224 89abcdef
2 0 2 1a 80000008 00000000 40000300 01234567
2 0 2 1b 80001084 00000000 40000304 5a5aa5a5
0 1 2 1c 8000003c 0f0f0f0f 00000000 00000000
0 0 2 1d 8000003c 00000000 40000308 0f0f0f0f

/* bench/mesh_checks.svh */
`ifndef MESH_CHECKS_SVH
`define MESH_CHECKS_SVH

//##############################
// ERROR COUNTERS
//##############################

int mismatch_count = 0;   // Wrong values on DUT outputs
int fail_count     = 0;   // Lost, extra or late traffic

//##############################
// COMPARE TASKS
//##############################

// Whole response packet against the expected one
task automatic check_packet(input string         name,
                            input emesh_packet_t actual,
                            input emesh_packet_t expected);
   if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, actual, expected);
   end
endtask

// Single control output such as access_out or wait_out
task automatic check_bit(input string name, input logic actual, input logic expected);
   if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, actual, expected);
   end
endtask

task automatic report_failure(input string what);
   fail_count++;
   $display("ERROR at %0t: %s", $time, what);
endtask

task automatic print_summary();
   $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
endtask

`endif

/* bench/mesh_tb.sv */
`timescale 1ns/1ps
`include "mesh_defines.svh"

module mesh_tb;

   import emesh_pkg::*;

   `include "mesh_checks.svh"

   logic          clk1;
   logic          rst_n;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;

   emesh_packet_t txn_pkt[$];    // Requests from the input file
   logic [31:0]   txn_exp[$];    // Read data due back
   int            txn_mode[$];   // 0 plain, 1 random wait_in, 2 latency
   emesh_packet_t exp_q[$];      // Responses still owed
   logic          bp_mode;       // Random pushback on
   logic [31:0]   rng_state;
   logic          loaded;        // Stimulus read in
   logic          hold_valid;    // Response held last edge
   emesh_packet_t hold_pkt;      // Its value then
   int            read_count;
   int            resp_count;
   int            lane_exp[`MESH_LANES];   // Packets due into each lane
   int            lane_got[`MESH_LANES];   // Packets each lane took

   initial clk1 = 1'b0;
   always #50 clk1 = ~clk1;      // 100 ns period

   mesh_link_top u_dut (.clk1      (clk1),
                        .rst_n     (rst_n),
                        .access_in (access_in),
                        .packet_in (packet_in),
                        .wait_out  (wait_out),
                        .access_out(access_out),
                        .packet_out(packet_out),
                        .wait_in   (wait_in));

   //##############################
   // HELPERS
   //##############################

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Read response built from the request by the responder's rules
   function automatic emesh_packet_t make_response(input emesh_packet_t req,
                                                   input logic [31:0]   rd_data);
      emesh_packet_t rsp;
      rsp.write    = 1'b0;
      rsp.datamode = req.datamode;
      rsp.ctrlmode = req.ctrlmode;
      rsp.dstaddr  = req.srcaddr;      // Back to the requester
      rsp.data     = rd_data;
      rsp.srcaddr  = req.dstaddr;
      return rsp;
   endfunction

   // Lane number from the address bits above the lane-select position
   function automatic int lane_of(input emesh_packet_t pkt);
      return int'(pkt.dstaddr >> `MESH_LANE_BIT) % `MESH_LANES;
   endfunction

   task automatic load_stimulus();
      int            fd;
      int            n;
      int            mode;
      string         line;
      logic [31:0]   f_wr;
      logic [31:0]   f_dm;
      logic [31:0]   f_cm;
      logic [31:0]   f_dst;
      logic [31:0]   f_data;
      logic [31:0]   f_src;
      logic [31:0]   f_exp;
      emesh_packet_t pkt;
      fd = $fopen("bench/mesh_input.txt", "r");
      if (fd == 0) begin
         report_failure("cannot open bench/mesh_input.txt");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.getc(0) == "#")
            continue;                                  // Blank or column notes
         n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                     mode, f_wr, f_dm, f_cm, f_dst, f_data, f_src, f_exp);
         if (n != 8) begin
            report_failure($sformatf("bad stimulus line: %s", line));
            continue;
         end
         pkt.write    = f_wr[0];
         pkt.datamode = f_dm[1:0];
         pkt.ctrlmode = f_cm[4:0];
         pkt.dstaddr  = f_dst;
         pkt.data     = f_data;
         pkt.srcaddr  = f_src;
         txn_pkt.push_back(pkt);
         txn_exp.push_back(f_exp);
         txn_mode.push_back(mode);
      end
      $fclose(fd);
   endtask

   // Hold the request until the selected lane lets it through
   task automatic send_txn(input emesh_packet_t pkt);
      access_in <= 1'b1;
      packet_in <= pkt;
      @(posedge clk1);
      while (wait_out)
         @(posedge clk1);
   endtask

   // Nothing owed, nothing in a lane, no response on the port
   task automatic wait_idle();
      access_in <= 1'b0;
      @(posedge clk1);
      while (exp_q.size() != 0 || u_dut.lane_wait != '0 || access_out || wait_in)
         @(posedge clk1);
   endtask

   // Response valid only after the 15th edge past acceptance
   task automatic expect_latency();
      repeat (15) begin
         @(posedge clk1);
         check_bit("access_out", access_out, 1'b0);
      end
      @(posedge clk1);
      check_bit("access_out", access_out, 1'b1);
   endtask

   // First owed response with this source keeps per-lane order
   task automatic match_response(input emesh_packet_t rsp);
      int idx;
      idx = -1;
      for (int i = 0; i < exp_q.size(); i++) begin
         if (idx < 0 && exp_q[i].srcaddr == rsp.srcaddr)
            idx = i;
      end
      resp_count++;
      if (idx < 0) begin
         report_failure($sformatf("unexpected response from address %h", rsp.srcaddr));
      end else begin
         check_packet("packet_out", rsp, exp_q[idx]);
         exp_q.delete(idx);
      end
   endtask

   //##############################
   // PUSHBACK AND MONITOR
   //##############################

   always @(posedge clk1) begin
      if (bp_mode) begin
         rng_state = xorshift32(rng_state);
         wait_in <= rng_state[7];          // About half the cycles
      end else begin
         wait_in <= 1'b0;
      end
   end

   always @(posedge clk1) begin
      if (!rst_n) begin
         hold_valid = 1'b0;
      end else begin
         for (int l = 0; l < `MESH_LANES; l++) begin
            if (u_dut.lane_access[l] && !u_dut.lane_wait[l])
               lane_got[l]++;                            // Lane took a packet
         end
         if (hold_valid)
            check_bit("access_out", access_out, 1'b1);   // Held response stays
         if (access_out) begin
            if (hold_valid)
               check_packet("packet_out", packet_out, hold_pkt);
            if (wait_in) begin
               hold_valid = 1'b1;
               hold_pkt   = packet_out;
            end else begin
               hold_valid = 1'b0;
               match_response(packet_out);             // Transfer this edge
            end
         end else begin
            hold_valid = 1'b0;
         end
      end
   end

   //##############################
   // MAIN SEQUENCE
   //##############################

   initial begin
      rst_n      = 1'b0;
      access_in  = 1'b0;
      packet_in  = '0;
      wait_in    = 1'b0;
      bp_mode    = 1'b0;
      hold_valid = 1'b0;
      loaded     = 1'b0;
      read_count = 0;
      resp_count = 0;
      rng_state  = 32'd81989;
      for (int l = 0; l < `MESH_LANES; l++) begin
         lane_exp[l] = 0;
         lane_got[l] = 0;
      end
      load_stimulus();
      if (txn_pkt.size() == 0)
         report_failure("no transactions in the stimulus file");
      loaded = 1'b1;
      repeat (2) @(posedge clk1);
      rst_n <= 1'b1;
      @(posedge clk1);
      check_bit("access_out", access_out, 1'b0);    // Quiet after reset
      check_bit("wait_out", wait_out, 1'b0);
      for (int i = 0; i < txn_pkt.size(); i++) begin
         bp_mode <= (txn_mode[i] == 1);
         if (txn_mode[i] == 2)
            wait_idle();
         send_txn(txn_pkt[i]);
         lane_exp[lane_of(txn_pkt[i])]++;
         if (!txn_pkt[i].write) begin
            exp_q.push_back(make_response(txn_pkt[i], txn_exp[i]));
            read_count++;
         end
         if (txn_mode[i] == 2) begin
            access_in <= 1'b0;
            expect_latency();
         end
      end
      bp_mode <= 1'b0;
      wait_idle();
      repeat (40) @(posedge clk1);                  // Room for stray duplicates
      if (resp_count != read_count)
         report_failure($sformatf("%0d reads sent but %0d responses seen",
                                  read_count, resp_count));
      for (int l = 0; l < `MESH_LANES; l++) begin
         if (lane_got[l] != lane_exp[l])
            report_failure($sformatf("lane %0d took %0d packets but %0d were due",
                                     l, lane_got[l], lane_exp[l]));
      end
      print_summary();
      if (mismatch_count == 0 && fail_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

   // Watchdog sized from the number of transactions
   initial begin
      int limit;
      wait (loaded === 1'b1);
      limit = txn_pkt.size() * 40 + 200;
      repeat (limit) @(posedge clk1);
      report_failure($sformatf("timeout after %0d cycles, traffic did not drain", limit));
      print_summary();
      $display("Test failures found");
      $finish;
   end

endmodule

/* hdl/emem_responder.sv */
`timescale 1ns/1ps
`include "mesh_defines.svh"

module emem_responder (
   input  logic                     clk1,         // Mesh clock
   input  logic                     rst_n,        // Sync reset
   input  logic                     access_in,    // From merge
   input  emesh_pkg::emesh_packet_t packet_in,    // From merge
   output logic                     wait_out,     // Stall to merge
   output logic                     access_out,   // Read response valid
   output emesh_pkg::emesh_packet_t packet_out,   // Read response
   input  logic                     wait_in       // Response pushback
);

   import emesh_pkg::*;

   localparam int AW = $clog2(`MESH_MEM_WORDS);   // Word address width

   logic [31:0]   mem [`MESH_MEM_WORDS];   // Word storage
   logic [AW-1:0] word_addr;               // Word index
   logic          accept;                  // Request taken
   logic          rd_accept;               // Read request taken
   logic          resp_valid;              // Response pending
   emesh_packet_t resp_q;                  // Response payload

   //##############################
   // REQUEST SIDE
   //##############################

   assign word_addr = packet_in.dstaddr[2 +: AW];      // Byte address to word
   assign wait_out  = resp_valid & wait_in;            // Held response blocks
   assign accept    = access_in & ~wait_out;
   assign rd_accept = accept & ~packet_in.write;

   // Writes land in the accept cycle, no response
   always_ff @(posedge clk1) begin
      if (accept && packet_in.write)
         mem[word_addr] <= packet_in.data;
   end

   //##############################
   // RESPONSE SIDE
   //##############################

   // Read response turns the addresses around
   always_ff @(posedge clk1) begin
      if (rd_accept) begin
         resp_q.write    <= 1'b0;                  // Responses are reads
         resp_q.datamode <= packet_in.datamode;
         resp_q.ctrlmode <= packet_in.ctrlmode;
         resp_q.dstaddr  <= packet_in.srcaddr;     // Back to the requester
         resp_q.data     <= mem[word_addr];        // Stored word
         resp_q.srcaddr  <= packet_in.dstaddr;     // Where it came from
      end
   end

   always_ff @(posedge clk1) begin
      if (!rst_n)
         resp_valid <= 1'b0;
      else if (rd_accept)
         resp_valid <= 1'b1;                       // New response
      else if (!wait_in)
         resp_valid <= 1'b0;                       // Taken downstream
   end

   assign access_out = resp_valid;
   assign packet_out = resp_q;                     // Stable while held

endmodule

/* hdl/emesh_dispatch.sv */
`timescale 1ns/1ps
`include "mesh_defines.svh"

module emesh_dispatch (
   input  logic                     access_in,     // Stimulus access
   input  emesh_pkg::emesh_packet_t packet_in,     // Stimulus packet
   output logic                     wait_out,      // Back to the stimulus
   output logic [`MESH_LANES-1:0]   lane_access,   // One-hot lane strobe
   output emesh_pkg::emesh_packet_t lane_packet,   // Shared by all lanes
   input  logic [`MESH_LANES-1:0]   lane_wait      // Per-lane stall
);

   import emesh_pkg::*;

   //##############################
   // LANE DECODE
   //##############################

   lane_idx_t lane_sel;   // Lane picked by the address

   // Lane select bits sit just above the local page
   assign lane_sel = packet_in.dstaddr[`MESH_LANE_BIT +: $bits(lane_idx_t)];

   //##############################
   // STEERING
   //##############################

   // Packet fans out to every lane, only the strobe is steered
   assign lane_packet = packet_in;

   always_comb begin
      lane_access           = '0;           // Idle lanes see nothing
      lane_access[lane_sel] = access_in;    // Selected lane only
   end

   // Sender holds access and packet while the chosen lane stalls,
   // so the decode stays stable and no state is needed here
   assign wait_out = lane_wait[lane_sel];   // Wait of the target lane

endmodule

/* hdl/emesh_pkg.sv */
`include "mesh_defines.svh"

package emesh_pkg;

   //##############################
   // PACKET FORMAT
   //##############################

   // Field order matches the 104-bit emesh layout, write on top
   typedef struct packed {
      logic        write;      // 1 for write, 0 for read
      logic [1:0]  datamode;   // Access size
      logic [4:0]  ctrlmode;   // Side-band control
      logic [31:0] dstaddr;    // Target address
      logic [31:0] data;       // Write data or read result
      logic [31:0] srcaddr;    // Return address for reads
   } emesh_packet_t;

   //##############################
   // LANE AND LINK TYPES
   //##############################

   typedef logic [$clog2(`MESH_LANES)-1:0] lane_idx_t;   // Lane number

   // One beat on the internal byte link
   typedef struct packed {
      logic       frame;       // High while a packet is on the wire
      logic [7:0] data;        // Packet byte, MSB first
   } link_beat_t;

endpackage

/* hdl/lane_merge.sv */
`timescale 1ns/1ps
`include "mesh_defines.svh"

module lane_merge (
   input  logic                                       clk1,        // Mesh clock
   input  logic                                       rst_n,       // Sync reset
   input  logic [`MESH_LANES-1:0]                     rx_access,   // Lane requests
   input  emesh_pkg::emesh_packet_t [`MESH_LANES-1:0] rx_packet,   // Lane packets
   output logic [`MESH_LANES-1:0]                     rx_wait,     // Lane stalls
   output logic                                       mem_access,  // To responder
   output emesh_pkg::emesh_packet_t                   mem_packet,  // To responder
   input  logic                                       mem_wait     // From responder
);

   import emesh_pkg::*;

   lane_idx_t rr_ptr;       // Lane with first claim
   lane_idx_t grant;        // Lane served this cycle
   lane_idx_t grant_next;   // Pointer after a transfer

   //##############################
   // ARBITER
   //##############################

   always_comb begin
      int lane;
      mem_access = 1'b0;
      grant      = rr_ptr;
      // Walk from the far end so the closest request to rr_ptr wins
      for (int i = `MESH_LANES - 1; i >= 0; i--) begin
         lane = (int'(rr_ptr) + i) % `MESH_LANES;
         if (rx_access[lane]) begin
            mem_access = 1'b1;
            grant      = lane_idx_t'(lane);
         end
      end
      rx_wait        = '1;                     // Losers hold
      rx_wait[grant] = mem_wait;               // Winner follows memory
      mem_packet     = rx_packet[grant];       // Winner's payload
   end

   assign grant_next = lane_idx_t'((int'(grant) + 1) % `MESH_LANES);

   //##############################
   // ROUND-ROBIN POINTER
   //##############################

   always_ff @(posedge clk1) begin
      if (!rst_n)
         rr_ptr <= '0;
      else if (mem_access && !mem_wait)
         rr_ptr <= grant_next;                 // Skip past the served lane
   end

endmodule

/* hdl/link_lane.sv */
`timescale 1ns/1ps
`include "mesh_defines.svh"

module link_lane (
   input  logic                     clk1,        // Mesh clock
   input  logic                     rst_n,       // Sync reset
   input  logic                     access_in,   // From dispatch
   input  emesh_pkg::emesh_packet_t packet_in,   // From dispatch
   output logic                     wait_out,    // Lane busy
   output logic                     rx_access,   // Rebuilt packet ready
   output emesh_pkg::emesh_packet_t rx_packet,   // Rebuilt packet
   input  logic                     rx_wait      // Stall from merge
);

   import emesh_pkg::*;

   localparam int CNT_W = $clog2(`MESH_PKT_BYTES);   // Byte counter width
   localparam int PKT_W = `MESH_PKT_BYTES * 8;       // Serialized bits

   logic             tx_active;   // Bytes left to send
   logic [CNT_W-1:0] tx_cnt;      // Byte being sent
   logic [PKT_W-1:0] tx_shift;    // Outgoing shift register
   logic             tx_load;     // Packet accepted
   logic             tx_last;     // Final byte this cycle
   link_beat_t       link_q;      // The internal link wire
   logic             rx_valid;    // Packet rebuilt and held
   logic [CNT_W-1:0] rx_cnt;      // Bytes received so far
   logic [PKT_W-1:0] rx_shift;    // Incoming shift register
   logic             rx_take;     // Merge took the packet

   assign tx_load = access_in & ~wait_out;                       // Handshake
   assign tx_last = tx_active & (tx_cnt == CNT_W'(`MESH_PKT_BYTES - 1));
   assign rx_take = rx_valid & ~rx_wait;                         // Handshake

   //##############################
   // TRANSMITTER
   //##############################

   always_ff @(posedge clk1) begin
      if (!rst_n) begin
         tx_active <= 1'b0;
         tx_cnt    <= '0;
         link_q    <= '0;                      // Frame low out of reset
      end else begin
         if (tx_load) begin
            tx_active <= 1'b1;                 // Start on next edge
            tx_cnt    <= '0;
         end else if (tx_active) begin
            tx_cnt <= tx_cnt + 1'b1;
            if (tx_last)
               tx_active <= 1'b0;              // Last byte goes out now
         end
         link_q.frame <= tx_active;            // Framed while sending
         link_q.data  <= tx_shift[PKT_W-1 -: 8];   // MSB byte first
      end
   end

   // Payload shifter
   always_ff @(posedge clk1) begin
      if (tx_load)
         tx_shift <= packet_in;                // Capture whole packet
      else if (tx_active)
         tx_shift <= tx_shift << 8;            // Next byte to the top
   end

   //##############################
   // RECEIVER
   //##############################

   always_ff @(posedge clk1) begin
      if (!rst_n) begin
         rx_valid <= 1'b0;
         rx_cnt   <= '0;
      end else begin
         if (link_q.frame) begin
            if (rx_cnt == CNT_W'(`MESH_PKT_BYTES - 1)) begin
               rx_cnt   <= '0;                 // Packet complete
               rx_valid <= 1'b1;
            end else begin
               rx_cnt <= rx_cnt + 1'b1;
            end
         end else if (rx_take) begin
            rx_valid <= 1'b0;                  // Handed to merge
         end
      end
   end

   // Byte assembly, first byte ends up on top
   always_ff @(posedge clk1) begin
      if (link_q.frame)
         rx_shift <= {rx_shift[PKT_W-9:0], link_q.data};
   end

   assign rx_access = rx_valid;
   assign rx_packet = emesh_packet_t'(rx_shift);

   //##############################
   // LANE WAIT
   //##############################

   // Transit, trailing frame and the hold under rx_wait all keep
   // the lane closed, one packet in flight at a time
   assign wait_out = tx_active | link_q.frame | rx_valid;

endmodule

/* hdl/mesh_defines.svh */
`ifndef MESH_DEFINES_SVH
`define MESH_DEFINES_SVH

//##############################
// MESH SIZING
//##############################

`define MESH_LANES      2        // Link lanes in the mesh
`define MESH_LANE_BIT   12       // Lowest dstaddr bit of the lane select
`define MESH_MEM_WORDS  64       // Responder depth in 32-bit words
`define MESH_PKT_BYTES  13       // Bytes per serialized packet

`endif

/* hdl/mesh_link_top.sv */
`timescale 1ns/1ps
`include "mesh_defines.svh"

module mesh_link_top (
   input  logic                     clk1,         // Mesh clock
   input  logic                     rst_n,        // Sync reset
   input  logic                     access_in,    // Stimulus transaction
   input  emesh_pkg::emesh_packet_t packet_in,
   output logic                     wait_out,
   output logic                     access_out,   // Read responses
   output emesh_pkg::emesh_packet_t packet_out,
   input  logic                     wait_in
);

   import emesh_pkg::*;

   logic [`MESH_LANES-1:0]                lane_access;   // Dispatch strobes
   emesh_packet_t                         lane_packet;   // Dispatch payload
   logic [`MESH_LANES-1:0]                lane_wait;     // Lane busy
   logic [`MESH_LANES-1:0]                rx_access;     // Lane outputs
   emesh_packet_t [`MESH_LANES-1:0]       rx_packet;
   logic [`MESH_LANES-1:0]                rx_wait;       // Merge stalls
   logic                                  mem_access;    // Merged request
   emesh_packet_t                         mem_packet;
   logic                                  mem_wait;

   //##############################
   // DISPATCH
   //##############################

   emesh_dispatch u_dispatch (.access_in  (access_in),
                              .packet_in  (packet_in),
                              .wait_out   (wait_out),
                              .lane_access(lane_access),
                              .lane_packet(lane_packet),
                              .lane_wait  (lane_wait));

   //##############################
   // LINK LANES
   //##############################

   for (genvar g = 0; g < `MESH_LANES; g++) begin : g_lane
      link_lane u_lane (.clk1     (clk1),
                        .rst_n    (rst_n),
                        .access_in(lane_access[g]),
                        .packet_in(lane_packet),
                        .wait_out (lane_wait[g]),
                        .rx_access(rx_access[g]),
                        .rx_packet(rx_packet[g]),
                        .rx_wait  (rx_wait[g]));
   end

   //##############################
   // MERGE AND MEMORY
   //##############################

   lane_merge u_merge (.clk1      (clk1),
                       .rst_n     (rst_n),
                       .rx_access (rx_access),
                       .rx_packet (rx_packet),
                       .rx_wait   (rx_wait),
                       .mem_access(mem_access),
                       .mem_packet(mem_packet),
                       .mem_wait  (mem_wait));

   emem_responder u_mem (.clk1      (clk1),
                         .rst_n     (rst_n),
                         .access_in (mem_access),
                         .packet_in (mem_packet),
                         .wait_out  (mem_wait),
                         .access_out(access_out),
                         .packet_out(packet_out),
                         .wait_in   (wait_in));   // Response pushback

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Verilator build and run of the mesh testbench, verdict taken from the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
   --top-module mesh_tb -f vlog.f -o mesh_sim > "$BUILD_LOG" 2>&1 \
   && ./obj_dir/mesh_sim > "$SIM_LOG" 2>&1 \
   || { echo "Build or simulation error, see $BUILD_LOG and $SIM_LOG"; exit 1; }

cat "$SIM_LOG"
grep -q 'All tests passed!' "$SIM_LOG" && echo "PASS" || { echo "FAIL"; exit 1; }

/* vlog.f */
+incdir+hdl
+incdir+bench
hdl/emesh_pkg.sv
hdl/emesh_dispatch.sv
hdl/link_lane.sv
hdl/lane_merge.sv
hdl/emem_responder.sv
hdl/mesh_link_top.sv
bench/mesh_tb.sv
